//--- include/dbg_defines.svh
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

`define DBG_BYTE_W 8
`define DBG_WORD_W 32
`define DBG_NUM_REGS 8
`define DBG_MEM_AW 6

`define DBG_IF_ID_W 64
`define DBG_ID_EX_W 129
`define DBG_EX_MEM_W 77
`define DBG_MEM_WB_W 71

`define DBG_ACK_BYTE 8'h52
`define DBG_RESET_CYCLES 16
`define DBG_STEP_MODE_BIT 1

`endif

//--- rtl/dbg_pkg.sv
`include "dbg_defines.svh"

package dbg_pkg;

    typedef enum logic [`DBG_BYTE_W-1:0] {
        CMD_DUMP_REGS  = 8'h01,
        CMD_DUMP_IF_ID = 8'h02,
        CMD_DUMP_ID_EX = 8'h03,
        CMD_DUMP_EX_MEM = 8'h04,
        CMD_DUMP_MEM_WB = 8'h05,
        CMD_DUMP_MEM   = 8'h06,
        CMD_LOAD       = 8'h07,
        CMD_CONT_MODE  = 8'h08,
        CMD_STEP_MODE  = 8'h09,
        CMD_STEP       = 8'h0A,
        CMD_MEM_ADDR   = 8'h0B
    } cmd_t;

    // Same order as dump commands 01 to 06
    typedef enum logic [2:0] {
        SRC_REGS,
        SRC_IF_ID,
        SRC_ID_EX,
        SRC_EX_MEM,
        SRC_MEM_WB,
        SRC_MEM
    } dump_src_t;

    localparam int REGS_BYTES   = (`DBG_NUM_REGS * `DBG_WORD_W + 7) / 8;
    localparam int IF_ID_BYTES  = (`DBG_IF_ID_W + 7) / 8;
    localparam int ID_EX_BYTES  = (`DBG_ID_EX_W + 7) / 8;
    localparam int EX_MEM_BYTES = (`DBG_EX_MEM_W + 7) / 8;
    localparam int MEM_WB_BYTES = (`DBG_MEM_WB_W + 7) / 8;
    localparam int MEM_BYTES    = (`DBG_WORD_W + 7) / 8;

endpackage

//--- rtl/dbg_ifs.sv
`timescale 1ns/1ns
`include "dbg_defines.svh"

interface dbg_cmd_if;
    import dbg_pkg::*;

    logic                   cmd_valid;
    cmd_t                   cmd;
    logic [`DBG_BYTE_W-1:0] arg;    // Count for 07, address for 0B
    logic                   data_valid;
    logic [`DBG_BYTE_W-1:0] data;   // Program bytes during a load
    logic                   dump_done;
    logic                   ctrl_done;

    modport decoder (output cmd_valid, cmd, arg, data_valid, data, input dump_done, ctrl_done);
    modport dumper  (input cmd_valid, cmd, arg, output dump_done);
    modport control (input cmd_valid, cmd, arg, data_valid, data, output ctrl_done);
endinterface

interface dbg_tx_if;
    logic                   req;
    logic [`DBG_BYTE_W-1:0] byte_data;
    logic                   last;       // Append 'R' after this byte
    logic                   ack_only;   // Send only 'R'
    logic                   done;

    modport client (output req, byte_data, last, ack_only, input done);
    modport framer (input req, byte_data, last, ack_only, output done);
endinterface

//--- rtl/cmd_decoder.sv
`timescale 1ns/1ns
`include "dbg_defines.svh"

module cmd_decoder (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_rx_valid,
    input  logic [`DBG_BYTE_W-1:0] i_rx_data,
    dbg_cmd_if.decoder             cmd
);
    import dbg_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ARG, ST_BUSY} state_t;

    state_t state;
    logic   loading;    // Forward bytes as program data
    logic   known;
    logic   needs_arg;
    logic   cmd_open;   // Issued command still waiting for its done

    assign known     = (i_rx_data >= CMD_DUMP_REGS) && (i_rx_data <= CMD_MEM_ADDR);
    assign needs_arg = (i_rx_data == CMD_LOAD) || (i_rx_data == CMD_MEM_ADDR);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state          <= ST_IDLE;
            loading        <= 1'b0;
            cmd.cmd_valid  <= 1'b0;
            cmd.data_valid <= 1'b0;
        end else begin
            cmd.cmd_valid  <= 1'b0;
            cmd.data_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_rx_valid && known) begin
                        if (needs_arg) begin
                            state <= ST_ARG;
                        end else begin
                            cmd.cmd_valid <= 1'b1;
                            state         <= ST_BUSY;
                        end
                    end
                end
                ST_ARG: begin
                    if (i_rx_valid) begin
                        cmd.cmd_valid <= 1'b1;
                        loading       <= (cmd.cmd == CMD_LOAD);
                        state         <= ST_BUSY;
                    end
                end
                default: begin
                    if (cmd.dump_done || cmd.ctrl_done) begin
                        loading <= 1'b0;
                        state   <= ST_IDLE;
                    end else if (i_rx_valid && loading) begin
                        cmd.data_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rx_valid) begin
            cmd.data <= i_rx_data;
            if (state == ST_IDLE) cmd.cmd <= cmd_t'(i_rx_data);
            if (state == ST_ARG) cmd.arg <= i_rx_data;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            cmd_open <= 1'b0;
        end else if (cmd.cmd_valid) begin
            cmd_open <= 1'b1;
        end else if (cmd.dump_done || cmd.ctrl_done) begin
            cmd_open <= 1'b0;
        end
    end

    // A command is only issued once the previous one has reported done
    assert property (@(posedge i_clk) disable iff (i_reset)
        cmd.cmd_valid |-> !cmd_open);

endmodule

//--- rtl/state_dumper.sv
`timescale 1ns/1ns
`include "dbg_defines.svh"

module state_dumper (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic [`DBG_NUM_REGS*`DBG_WORD_W-1:0] i_regs,
    input  logic [`DBG_IF_ID_W-1:0]              i_if_id,
    input  logic [`DBG_ID_EX_W-1:0]              i_id_ex,
    input  logic [`DBG_EX_MEM_W-1:0]             i_ex_mem,
    input  logic [`DBG_MEM_WB_W-1:0]             i_mem_wb,
    input  logic [`DBG_WORD_W-1:0]               i_mem_data,
    output logic [`DBG_MEM_AW-1:0]               o_mem_addr,
    output logic                                 o_mem_rd,
    dbg_cmd_if.dumper                            cmd,
    dbg_tx_if.client                             tx
);
    import dbg_pkg::*;

    localparam int CNT_W = $clog2(REGS_BYTES + 1);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_SEND, ST_GAP} state_t;

    state_t                         state;
    dump_src_t                      src;
    logic [CNT_W-1:0]               idx;      // Byte being sent
    logic [CNT_W-1:0]               count;
    logic [`DBG_BYTE_W-1:0]         cur_byte;
    logic                           is_dump;
    logic                           is_mem;
    logic [ID_EX_BYTES*8-1:0]       id_ex_p;
    logic [EX_MEM_BYTES*8-1:0]      ex_mem_p;
    logic [MEM_WB_BYTES*8-1:0]      mem_wb_p;

    // Zero padding up to whole bytes
    assign id_ex_p  = (ID_EX_BYTES * 8)'(i_id_ex);
    assign ex_mem_p = (EX_MEM_BYTES * 8)'(i_ex_mem);
    assign mem_wb_p = (MEM_WB_BYTES * 8)'(i_mem_wb);

    assign is_mem  = (cmd.cmd == CMD_DUMP_MEM) || (cmd.cmd == CMD_MEM_ADDR);
    assign is_dump = cmd.cmd_valid && ((cmd.cmd <= CMD_DUMP_MEM) || is_mem);

    always_comb begin
        case (src)
            SRC_REGS: begin
                cur_byte = i_regs[idx*8 +: 8];
                count    = CNT_W'(REGS_BYTES);
            end
            SRC_IF_ID: begin
                cur_byte = i_if_id[idx*8 +: 8];
                count    = CNT_W'(IF_ID_BYTES);
            end
            SRC_ID_EX: begin
                cur_byte = id_ex_p[idx*8 +: 8];
                count    = CNT_W'(ID_EX_BYTES);
            end
            SRC_EX_MEM: begin
                cur_byte = ex_mem_p[idx*8 +: 8];
                count    = CNT_W'(EX_MEM_BYTES);
            end
            SRC_MEM_WB: begin
                cur_byte = mem_wb_p[idx*8 +: 8];
                count    = CNT_W'(MEM_WB_BYTES);
            end
            default: begin
                cur_byte = i_mem_data[idx*8 +: 8];
                count    = CNT_W'(MEM_BYTES);
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state         <= ST_IDLE;
            src           <= SRC_REGS;
            idx           <= '0;
            o_mem_addr    <= '0;
            o_mem_rd      <= 1'b0;
            cmd.dump_done <= 1'b0;
        end else begin
            o_mem_rd      <= 1'b0;
            cmd.dump_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (is_dump) begin
                        idx <= '0;
                        src <= is_mem ? SRC_MEM : dump_src_t'(3'(cmd.cmd - 8'd1));
                        if (cmd.cmd == CMD_MEM_ADDR) o_mem_addr <= cmd.arg[`DBG_MEM_AW-1:0];
                        o_mem_rd <= is_mem;
                        state    <= is_mem ? ST_READ : ST_SEND;
                    end
                end
                ST_READ: state <= ST_SEND;    // Word valid from the next cycle
                ST_SEND: begin
                    if (tx.done) begin
                        if (tx.last) begin
                            cmd.dump_done <= 1'b1;
                            state         <= ST_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= ST_GAP;
                        end
                    end
                end
                default: state <= ST_SEND;
            endcase
        end
    end

    assign tx.req       = (state == ST_SEND);
    assign tx.byte_data = cur_byte;
    assign tx.last      = (idx == count - 1'b1);
    assign tx.ack_only  = 1'b0;

    assert property (@(posedge i_clk) disable iff (i_reset)
        state != ST_IDLE |-> idx < count);

endmodule

//--- rtl/core_control.sv
`timescale 1ns/1ns
`include "dbg_defines.svh"

module core_control (
    input  logic                   i_clk,
    input  logic                   i_reset,
    output logic                   o_imem_we,
    output logic [`DBG_MEM_AW-1:0] o_imem_addr,
    output logic [`DBG_WORD_W-1:0] o_imem_data,
    output logic                   o_prog_reset,
    output logic                   o_mode,
    output logic                   o_step,
    dbg_cmd_if.control             cmd,
    dbg_tx_if.client               tx
);
    import dbg_pkg::*;

    localparam logic STEP_MODE = 1'(`DBG_STEP_MODE_BIT);
    localparam int   RST_W     = $clog2(`DBG_RESET_CYCLES);

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_RESET, ST_ACK} state_t;

    state_t                 state;
    logic [1:0]             lane;       // Byte position inside the word
    logic [`DBG_BYTE_W-1:0] words_left;
    logic [RST_W-1:0]       rst_cnt;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state         <= ST_IDLE;
            lane          <= '0;
            words_left    <= '0;
            rst_cnt       <= '0;
            o_imem_we     <= 1'b0;
            o_imem_addr   <= '0;
            o_prog_reset  <= 1'b0;
            o_mode        <= ~STEP_MODE;
            o_step        <= 1'b0;
            cmd.ctrl_done <= 1'b0;
        end else begin
            o_imem_we     <= 1'b0;
            o_step        <= 1'b0;
            cmd.ctrl_done <= 1'b0;
            if (o_imem_we) begin
                o_imem_addr <= o_imem_addr + 1'b1;
                words_left  <= words_left - 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (cmd.cmd_valid) begin
                        case (cmd.cmd)
                            CMD_CONT_MODE: begin
                                o_mode        <= ~STEP_MODE;
                                cmd.ctrl_done <= 1'b1;
                            end
                            CMD_STEP_MODE: begin
                                o_mode        <= STEP_MODE;
                                cmd.ctrl_done <= 1'b1;
                            end
                            CMD_STEP: begin
                                o_step        <= 1'b1;
                                cmd.ctrl_done <= 1'b1;
                            end
                            CMD_LOAD: begin
                                words_left  <= cmd.arg;
                                lane        <= '0;
                                o_imem_addr <= '0;
                                rst_cnt     <= '0;
                                // Empty program goes straight to the core reset
                                o_prog_reset <= (cmd.arg == '0);
                                state        <= (cmd.arg == '0) ? ST_RESET : ST_LOAD;
                            end
                            default: state <= ST_IDLE;
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (cmd.data_valid) begin
                        lane <= lane + 1'b1;
                        if (lane == 2'd3) o_imem_we <= 1'b1;
                    end
                    if (o_imem_we && words_left == 8'd1) begin
                        o_prog_reset <= 1'b1;
                        state        <= ST_RESET;
                    end
                end
                ST_RESET: begin
                    if (rst_cnt == RST_W'(`DBG_RESET_CYCLES - 1)) begin
                        o_prog_reset <= 1'b0;
                        state        <= ST_ACK;
                    end else begin
                        rst_cnt <= rst_cnt + 1'b1;
                    end
                end
                default: begin
                    if (tx.done) begin
                        cmd.ctrl_done <= 1'b1;
                        state         <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Little-endian packing, the first byte ends up in bits 7:0
    always_ff @(posedge i_clk) begin
        if (cmd.data_valid) o_imem_data <= {cmd.data, o_imem_data[`DBG_WORD_W-1:`DBG_BYTE_W]};
    end

    assign tx.req       = (state == ST_ACK);
    assign tx.byte_data = `DBG_ACK_BYTE;
    assign tx.last      = 1'b0;
    assign tx.ack_only  = 1'b1;

    assert property (@(posedge i_clk) disable iff (i_reset)
        o_prog_reset |-> !o_imem_we);

endmodule

//--- rtl/tx_framer.sv
`timescale 1ns/1ns
`include "dbg_defines.svh"

module tx_framer (
    input  logic                   i_clk,
    input  logic                   i_reset,
    output logic                   o_tx_start,
    output logic [`DBG_BYTE_W-1:0] o_tx_data,
    input  logic                   i_tx_busy,
    dbg_tx_if.framer               dump_tx,
    dbg_tx_if.framer               ctrl_tx
);
    typedef enum logic [1:0] {ST_IDLE, ST_RISE, ST_FALL, ST_GAP} state_t;

    state_t                 state;
    logic                   grant_ctrl;
    logic                   ack_phase;  // Byte on the link is the 'R'
    logic                   use_ctrl;
    logic [`DBG_BYTE_W-1:0] sel_byte;
    logic                   sel_last;
    logic                   sel_ack_only;

    // Dumper wins when both ask
    assign use_ctrl     = (state == ST_IDLE) ? !dump_tx.req : grant_ctrl;
    assign sel_byte     = use_ctrl ? ctrl_tx.byte_data : dump_tx.byte_data;
    assign sel_last     = use_ctrl ? ctrl_tx.last : dump_tx.last;
    assign sel_ack_only = use_ctrl ? ctrl_tx.ack_only : dump_tx.ack_only;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            grant_ctrl   <= 1'b0;
            ack_phase    <= 1'b0;
            o_tx_start   <= 1'b0;
            o_tx_data    <= '0;
            dump_tx.done <= 1'b0;
            ctrl_tx.done <= 1'b0;
        end else begin
            o_tx_start   <= 1'b0;
            dump_tx.done <= 1'b0;
            ctrl_tx.done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (dump_tx.req || ctrl_tx.req) begin
                        grant_ctrl <= use_ctrl;
                        ack_phase  <= sel_ack_only;
                        o_tx_data  <= sel_ack_only ? `DBG_ACK_BYTE : sel_byte;
                        o_tx_start <= 1'b1;
                        state      <= ST_RISE;
                    end
                end
                ST_RISE: begin
                    if (i_tx_busy) state <= ST_FALL;
                end
                ST_FALL: begin
                    if (!i_tx_busy) begin
                        if (sel_last && !ack_phase) begin
                            ack_phase  <= 1'b1;
                            o_tx_data  <= `DBG_ACK_BYTE;
                            o_tx_start <= 1'b1;
                            state      <= ST_RISE;
                        end else begin
                            dump_tx.done <= !grant_ctrl;
                            ctrl_tx.done <= grant_ctrl;
                            state        <= ST_GAP;
                        end
                    end
                end
                default: state <= ST_IDLE;    // Client drops req here
            endcase
        end
    end

    assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_tx_start) |-> !i_tx_busy);

endmodule

//--- rtl/debug_unit.sv
`timescale 1ns/1ns
`include "dbg_defines.svh"

module debug_unit (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic                                 i_rx_valid,
    input  logic [`DBG_BYTE_W-1:0]               i_rx_data,
    output logic                                 o_tx_start,
    output logic [`DBG_BYTE_W-1:0]               o_tx_data,
    input  logic                                 i_tx_busy,
    input  logic [`DBG_NUM_REGS*`DBG_WORD_W-1:0] i_regs,
    input  logic [`DBG_IF_ID_W-1:0]              i_if_id,
    input  logic [`DBG_ID_EX_W-1:0]              i_id_ex,
    input  logic [`DBG_EX_MEM_W-1:0]             i_ex_mem,
    input  logic [`DBG_MEM_WB_W-1:0]             i_mem_wb,
    input  logic [`DBG_WORD_W-1:0]               i_mem_data,
    output logic [`DBG_MEM_AW-1:0]               o_mem_addr,
    output logic                                 o_mem_rd,
    output logic                                 o_imem_we,
    output logic [`DBG_MEM_AW-1:0]               o_imem_addr,
    output logic [`DBG_WORD_W-1:0]               o_imem_data,
    output logic                                 o_prog_reset,
    output logic                                 o_mode,
    output logic                                 o_step
);
    dbg_cmd_if cmd_bus ();
    dbg_tx_if  dump_tx ();
    dbg_tx_if  ctrl_tx ();

    cmd_decoder u_decoder (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data),
        .cmd        (cmd_bus)
    );

    state_dumper u_dumper (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_regs     (i_regs),
        .i_if_id    (i_if_id),
        .i_id_ex    (i_id_ex),
        .i_ex_mem   (i_ex_mem),
        .i_mem_wb   (i_mem_wb),
        .i_mem_data (i_mem_data),
        .o_mem_addr (o_mem_addr),
        .o_mem_rd   (o_mem_rd),
        .cmd        (cmd_bus),
        .tx         (dump_tx)
    );

    core_control u_control (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .o_imem_we    (o_imem_we),
        .o_imem_addr  (o_imem_addr),
        .o_imem_data  (o_imem_data),
        .o_prog_reset (o_prog_reset),
        .o_mode       (o_mode),
        .o_step       (o_step),
        .cmd          (cmd_bus),
        .tx           (ctrl_tx)
    );

    tx_framer u_framer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data),
        .i_tx_busy  (i_tx_busy),
        .dump_tx    (dump_tx),
        .ctrl_tx    (ctrl_tx)
    );

endmodule

//--- tb/tb_checker.sv
`timescale 1ns/1ns
`include "dbg_defines.svh"

module tb_checker (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic                                 i_tx_start,
    input  logic [7:0]                           i_tx_data,
    input  logic                                 i_tx_busy,
    input  logic [`DBG_NUM_REGS*`DBG_WORD_W-1:0] i_regs,
    input  logic [`DBG_IF_ID_W-1:0]              i_if_id,
    input  logic [`DBG_ID_EX_W-1:0]              i_id_ex,
    input  logic [`DBG_EX_MEM_W-1:0]             i_ex_mem,
    input  logic [`DBG_MEM_WB_W-1:0]             i_mem_wb,
    input  logic [`DBG_MEM_AW-1:0]               i_mem_addr,
    input  logic                                 i_mem_rd,
    input  logic                                 i_imem_we,
    input  logic [`DBG_MEM_AW-1:0]               i_imem_addr,
    input  logic [31:0]                          i_imem_data,
    input  logic                                 i_prog_reset,
    input  logic                                 i_mode,
    input  logic                                 i_step,
    input  logic                                 i_test_start,
    input  logic                                 i_test_end,
    input  logic [7:0]                           i_row_cmd,
    input  logic [7:0]                           i_row_arg,
    input  logic [8*32-1:0]                      i_prog,
    output logic                                 o_exp_empty,
    output int                                   o_errors,
    output int                                   o_failed
);
    logic [7:0] exp_q[$];   // Bytes still to come on the link
    logic [7:0] cur_cmd;
    logic [7:0] cur_arg;
    logic [7:0] b;
    logic       mode_model;
    logic       prev_we;
    int         test_errs, tests, writes, rd_pulses, steps, rst_high, rst_pulses;

    function automatic logic [31:0] mem_word(input logic [5:0] a);
        return {a, 2'b01, ~a, 2'b10, a ^ 6'h2a, 2'b11, a + 6'd17, 2'b00};
    endfunction

    task automatic value_error(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        o_errors++;
        test_errs++;
    endtask

    task automatic other_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        o_errors++;
        test_errs++;
    endtask

    // LSB first, then the acknowledge byte
    task automatic queue_bytes(input logic [255:0] v, input int width);
        for (int i = 0; i < (width + 7) / 8; i++) exp_q.push_back(v[i*8 +: 8]);
        exp_q.push_back(8'h52);
    endtask

    initial begin
        o_errors    = 0;
        o_failed    = 0;
        tests       = 0;
        mode_model  = 1'b0;
        prev_we     = 1'b0;
        rst_high    = 0;
        o_exp_empty = 1'b1;
    end

    always @(posedge i_clk) begin
        if (!i_reset) begin
            if (i_test_start) begin
                cur_cmd   = i_row_cmd;
                cur_arg   = i_row_arg;
                test_errs = 0;
                writes    = 0;
                rd_pulses = 0;
                steps     = 0;
                rst_pulses = 0;
                exp_q.delete();
                case (i_row_cmd)
                    8'h01: queue_bytes(256'(i_regs), `DBG_NUM_REGS * 32);
                    8'h02: queue_bytes(256'(i_if_id), `DBG_IF_ID_W);
                    8'h03: queue_bytes(256'(i_id_ex), `DBG_ID_EX_W);
                    8'h04: queue_bytes(256'(i_ex_mem), `DBG_EX_MEM_W);
                    8'h05: queue_bytes(256'(i_mem_wb), `DBG_MEM_WB_W);
                    8'h0B: queue_bytes(256'(mem_word(i_row_arg[5:0])), 32);
                    8'h07: exp_q.push_back(8'h52);
                    8'h08: mode_model = 1'b0;
                    8'h09: mode_model = 1'b1;
                    default: ;
                endcase
            end
            if (i_tx_start) begin
                if (i_tx_busy) other_error("byte started while the link was busy");
                if (exp_q.size() == 0) begin
                    other_error($sformatf("unexpected byte %02h sent", i_tx_data));
                end else begin
                    if (cur_cmd == 8'h07 && rst_pulses == 0)
                        other_error("acknowledge sent before the core reset ended");
                    b = exp_q.pop_front();
                    if (i_tx_data != b)
                        value_error($sformatf("tx byte %02h, expected %02h", i_tx_data, b));
                end
            end
            if (i_mem_rd) begin
                rd_pulses++;
                if (i_mem_addr != cur_arg[5:0])
                    value_error($sformatf("read address %0d, expected %0d", i_mem_addr,
                                          cur_arg[5:0]));
            end
            if (i_imem_we) begin
                if (cur_cmd != 8'h07 || writes >= cur_arg) begin
                    other_error("instruction write outside a program load");
                end else if (i_imem_addr != writes || i_imem_data != i_prog[writes*32 +: 32]) begin
                    value_error($sformatf("write %0d: %08h at %0d, expected %08h", writes,
                                          i_imem_data, i_imem_addr, i_prog[writes*32 +: 32]));
                end
                writes++;
            end
            if (i_prog_reset) begin
                if (rst_high == 0 &&
                    (writes != int'(cur_arg) || (cur_arg != 0 && !prev_we)))
                    other_error("core reset did not follow the last write");
                rst_high++;
            end else if (rst_high > 0) begin
                rst_pulses++;
                if (rst_high != `DBG_RESET_CYCLES)
                    value_error($sformatf("core reset held %0d cycles", rst_high));
                rst_high = 0;
            end
            if (i_step) steps++;
            prev_we = i_imem_we;
            if (i_test_end) begin
                if (exp_q.size() != 0) other_error("bytes missing on the link");
                if (writes != ((cur_cmd == 8'h07) ? int'(cur_arg) : 0))
                    value_error($sformatf("%0d instruction writes", writes));
                if (rd_pulses != ((cur_cmd == 8'h0B) ? 1 : 0))
                    value_error($sformatf("%0d memory read pulses", rd_pulses));
                if (steps != ((cur_cmd == 8'h0A) ? 1 : 0))
                    value_error($sformatf("%0d step pulses", steps));
                if (rst_pulses != ((cur_cmd == 8'h07) ? 1 : 0))
                    value_error($sformatf("%0d core reset pulses", rst_pulses));
                if (i_mode != mode_model) value_error($sformatf("mode %0d", i_mode));
                tests++;
                if (test_errs != 0) o_failed++;
                $display("test %0d cmd %02h: %s", tests, cur_cmd,
                         (test_errs == 0) ? "ok" : "failed");
            end
            o_exp_empty = (exp_q.size() == 0);
        end
    end

endmodule

//--- tb/tb_debug_unit.sv
`timescale 1ns/1ns
`include "dbg_defines.svh"

module tb_debug_unit;
    localparam int CYCLE      = 100;
    localparam int NUM_ROWS   = 19;
    localparam int ROW_CYCLES = (`DBG_NUM_REGS * 4 + 1) * 10 + 8 * 4 * 3 + 80;

    logic                                 i_clk, i_reset, i_rx_valid, i_tx_busy;
    logic [7:0]                           i_rx_data, o_tx_data;
    logic                                 o_tx_start, o_mem_rd, o_imem_we;
    logic [`DBG_NUM_REGS*`DBG_WORD_W-1:0] i_regs;
    logic [`DBG_IF_ID_W-1:0]              i_if_id;
    logic [`DBG_ID_EX_W-1:0]              i_id_ex;
    logic [`DBG_EX_MEM_W-1:0]             i_ex_mem;
    logic [`DBG_MEM_WB_W-1:0]             i_mem_wb;
    logic [31:0]                          i_mem_data, o_imem_data;
    logic [`DBG_MEM_AW-1:0]               o_mem_addr, o_imem_addr;
    logic                                 o_prog_reset, o_mode, o_step;
    logic                                 test_start, test_end, exp_empty;
    logic [7:0]                           row_cmd, row_arg;
    logic [8*32-1:0]                      prog;
    logic [31:0]                          data_rng, link_rng;
    logic                                 start_seen;
    int                                   busy_left, errors, failed;

    // Columns: command, argument, program words, fresh core state
    logic [7:0] tbl_cmd [NUM_ROWS] = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h0B, 8'h0B,
        8'h07, 8'h07, 8'h07, 8'h09, 8'h0A, 8'h0A, 8'h08, 8'h0C, 8'hff, 8'h00, 8'h01, 8'h03};
    logic [7:0] tbl_arg [NUM_ROWS] = '{0, 0, 0, 0, 0, 8'h05, 8'hea,
        0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    int         tbl_words [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 3, 0, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    logic       tbl_new [NUM_ROWS] = '{1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1};

    debug_unit u_dut (.*);

    tb_checker u_chk (
        .i_clk (i_clk), .i_reset (i_reset), .i_tx_start (o_tx_start), .i_tx_data (o_tx_data),
        .i_tx_busy (i_tx_busy), .i_regs (i_regs), .i_if_id (i_if_id), .i_id_ex (i_id_ex),
        .i_ex_mem (i_ex_mem), .i_mem_wb (i_mem_wb), .i_mem_addr (o_mem_addr),
        .i_mem_rd (o_mem_rd), .i_imem_we (o_imem_we), .i_imem_addr (o_imem_addr),
        .i_imem_data (o_imem_data), .i_prog_reset (o_prog_reset), .i_mode (o_mode),
        .i_step (o_step), .i_test_start (test_start), .i_test_end (test_end),
        .i_row_cmd (row_cmd), .i_row_arg (row_arg), .i_prog (prog),
        .o_exp_empty (exp_empty), .o_errors (errors), .o_failed (failed)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Data memory model, every address bit shows up in the word
    function automatic logic [31:0] mem_word(input logic [5:0] a);
        return {a, 2'b01, ~a, 2'b10, a ^ 6'h2a, 2'b11, a + 6'd17, 2'b00};
    endfunction

    assign i_mem_data = mem_word(o_mem_addr);

    initial i_clk = 1'b0;
    always #(CYCLE / 2) i_clk = ~i_clk;

    // Link raises busy after the start pulse and holds it for 1 to 6 cycles
    always @(negedge i_clk) begin
        if (i_tx_busy) begin
            busy_left--;
            if (busy_left == 0) i_tx_busy = 1'b0;
        end else if (start_seen) begin
            link_rng  = xorshift(link_rng);
            busy_left = 1 + int'(link_rng % 6);
            i_tx_busy = 1'b1;
        end
        start_seen = o_tx_start;
    end

    task automatic random_vec(output logic [255:0] v);
        for (int i = 0; i < 8; i++) begin
            data_rng     = xorshift(data_rng);
            v[i*32 +: 32] = data_rng;
        end
    endtask

    task automatic randomize_core;
        logic [255:0] v;
        random_vec(v);
        i_regs = v;
        random_vec(v);
        i_if_id  = v[`DBG_IF_ID_W-1:0];
        i_ex_mem = v[64 +: `DBG_EX_MEM_W];
        random_vec(v);
        i_id_ex  = v[`DBG_ID_EX_W-1:0];
        random_vec(v);
        i_mem_wb = v[`DBG_MEM_WB_W-1:0];
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(negedge i_clk);
        i_rx_valid = 1'b1;
        i_rx_data  = b;
        @(negedge i_clk);
        i_rx_valid = 1'b0;
        @(negedge i_clk);
    endtask

    task automatic run_row(input int r);
        @(negedge i_clk);
        if (tbl_new[r]) randomize_core();
        for (int w = 0; w < tbl_words[r]; w++) begin
            data_rng         = xorshift(data_rng);
            prog[w*32 +: 32] = data_rng;
        end
        row_cmd    = tbl_cmd[r];
        row_arg    = (tbl_cmd[r] == 8'h07) ? 8'(tbl_words[r]) : tbl_arg[r];
        test_start = 1'b1;
        @(negedge i_clk);
        test_start = 1'b0;
        send_byte(row_cmd);
        if (row_cmd == 8'h07 || row_cmd == 8'h0B) send_byte(row_arg);
        for (int k = 0; k < tbl_words[r] * 4; k++) send_byte(prog[k*8 +: 8]);
        while (!exp_empty || i_tx_busy) @(negedge i_clk);
        repeat (12) @(negedge i_clk);
        test_end = 1'b1;
        @(negedge i_clk);
        test_end = 1'b0;
    endtask

    initial begin
        i_reset    = 1'b1;
        i_rx_valid = 1'b0;
        i_rx_data  = '0;
        i_tx_busy  = 1'b0;
        start_seen = 1'b0;
        busy_left  = 0;
        test_start = 1'b0;
        test_end   = 1'b0;
        row_cmd    = '0;
        row_arg    = '0;
        prog       = '0;
        data_rng   = 32'hbac9;
        link_rng   = 32'hbac9;
        randomize_core();
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) run_row(r);
        $display("%0d tests, %0d failed, %0d errors", NUM_ROWS, failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_ROWS * ROW_CYCLES * CYCLE);
        $display("timeout: the DUT stopped answering before all tests ended");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- debug_unit.f
+incdir+include
rtl/dbg_pkg.sv
rtl/dbg_ifs.sv
rtl/cmd_decoder.sv
rtl/state_dumper.sv
rtl/core_control.sv
rtl/tx_framer.sv
rtl/debug_unit.sv
tb/tb_checker.sv
tb/tb_debug_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_debug_unit
FILELIST  ?= debug_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
